// ==== dv/vector_alu_tb.sv ====
`timescale 1ns/1ns

`include "valu_params.svh"

module vector_alu_tb
    import valu_op_pkg::*, valu_lane_pkg::*;
;

    localparam int clk_period = 40;
    localparam int drive_delay = 2;   // inputs change this long after the rising edge
    localparam int max_cycles = 1000; // tests need about 730 cycles
    localparam int n_random = 600;

    logic        clk;
    logic        arst_n;
    logic        op_valid;
    valu_op_e    alu_op;
    elem_width_e width;
    dword_t      reg_a_data;
    dword_t      reg_b_data;
    dword_t      alu_out;
    logic        result_valid;

    logic [`VALU_DATA_W-1:0] held_result = '0; // one-deep expected register
    string                   test_name = "reset";
    int                      cycles = 0;

    vector_alu dut_i (
        .clk          (clk),
        .arst_n       (arst_n),
        .op_valid     (op_valid),
        .alu_op       (alu_op),
        .width        (width),
        .reg_a_data   (reg_a_data),
        .reg_b_data   (reg_b_data),
        .alu_out      (alu_out),
        .result_valid (result_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period/2) clk = ~clk;
    end

    // lane size in bits, 8 << width code
    function automatic int lane_size(input logic [1:0] w);
        return 8 << w;
    endfunction

    // same value in every lane
    function automatic logic [63:0] fill_lanes(input logic [63:0] val, input logic [1:0] w);
        int          size;
        logic [63:0] r;
        size = lane_size(w);
        r = '0;
        for (int p = 0; p < 64 / size; p++) begin
            r = r | (val << (p*size));
        end
        return r;
    endfunction

    // reference model, lanes handled as shifted and masked 64-bit values
    function automatic logic [63:0] expected_result(input logic [5:0] op, input logic [1:0] w,
                                                    input logic [63:0] a, input logic [63:0] b);
        int          size;
        int          lanes;
        int          slots;
        int          src;
        logic [63:0] mask;
        logic [63:0] la;
        logic [63:0] lb;
        logic [63:0] lane_r;
        logic [63:0] r;
        size  = lane_size(w);
        lanes = 64 / size;
        mask  = (size == 64) ? '1 : ((64'd1 << size) - 64'd1);
        r = '0;
        case (op)
            VAND: r = a & b;
            VOR:  r = a | b;
            VXOR: r = a ^ b;
            VNOT: r = ~a;
            VADD, VSUB, VSLL, VSRL, VRTTH: begin
                for (int p = 0; p < lanes; p++) begin // p counts lanes from the lsb end
                    la = (a >> (p*size)) & mask;
                    lb = (b >> (p*size)) & mask;
                    case (op)
                        VADD:    lane_r = la + lb;
                        VSUB:    lane_r = la - lb;
                        VSLL:    lane_r = la << (lb & 64'(size - 1));
                        VSRL:    lane_r = la >> (lb & 64'(size - 1));
                        default: lane_r = (la >> (size/2)) | (la << (size/2)); // half swap
                    endcase
                    r = r | ((lane_r & mask) << (p*size));
                end
            end
            VMULEU, VMULOU: begin
                if (size < 64) begin // doubleword multiply stays zero
                    slots = lanes / 2;
                    for (int k = 0; k < slots; k++) begin
                        src = 2*k + ((op == VMULOU) ? 1 : 0); // lane number from the msb end
                        la = (a >> ((lanes - 1 - src)*size)) & mask;
                        lb = (b >> ((lanes - 1 - src)*size)) & mask;
                        r = r | ((la * lb) << ((slots - 1 - k)*2*size));
                    end
                end
            end
            default: r = '0; // nop and undefined codes
        endcase
        return r;
    endfunction

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            $display("error: %s expected %h actual %h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "value mismatch in %s", name);
        end
    endtask

    // compare after the edge, inputs still hold the op sampled at this edge
    always @(posedge clk) begin
        logic [63:0] exp_now;
        logic        issued;
        if (arst_n) begin
            issued  = op_valid;
            exp_now = expected_result(alu_op, width, reg_a_data, reg_b_data);
            #1;
            check({test_name, " valid"}, {63'd0, issued}, {63'd0, result_valid});
            if (issued) begin
                held_result = exp_now;
            end
            check(test_name, held_result, alu_out); // also covers hold on idle cycles
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles >= max_cycles) begin
            $display("Test failed");
            $fatal(1, "timeout, run did not finish within %0d cycles", max_cycles);
        end
    end

    // one op per call, returns drive_delay after the edge that took it
    task automatic issue_op(input logic [5:0] code, input logic [1:0] w,
                            input logic [63:0] a, input logic [63:0] b, input string name);
        test_name  = name;
        op_valid   = 1'b1;
        alu_op     = valu_op_e'(code);
        width      = elem_width_e'(w);
        reg_a_data = a;
        reg_b_data = b;
        @(posedge clk);
        #(drive_delay);
    endtask

    task automatic idle_cycle();
        op_valid   = 1'b0;
        reg_a_data = {$urandom, $urandom}; // junk operands, output must not move
        reg_b_data = {$urandom, $urandom};
        @(posedge clk);
        #(drive_delay);
    endtask

    // kept opcodes plus nop and one undefined code
    function automatic logic [5:0] random_opcode();
        logic [5:0] code;
        case ($urandom % 13)
            0:       code = VAND;
            1:       code = VOR;
            2:       code = VXOR;
            3:       code = VNOT;
            4:       code = VADD;
            5:       code = VSUB;
            6:       code = VMULEU;
            7:       code = VMULOU;
            8:       code = VSLL;
            9:       code = VSRL;
            10:      code = VRTTH;
            11:      code = VNOP;
            default: code = 6'd63; // not in the opcode set
        endcase
        return code;
    endfunction

    initial begin
        logic [1:0]  w;
        logic [63:0] ones;
        logic [63:0] amt_b;
        int          size;
        int          amt;
        void'($urandom(10938));
        arst_n     = 1'b0;
        op_valid   = 1'b0;
        alu_op     = VNOP;
        width      = W_BYTE;
        reg_a_data = '0;
        reg_b_data = '0;
        repeat (2) @(posedge clk);
        #(drive_delay);
        arst_n = 1'b1;
        check("reset valid", 64'd0, {63'd0, result_valid});
        check("reset out", 64'd0, alu_out);
        idle_cycle();

        // carries and borrows must stay inside each lane
        for (int wi = 0; wi < 4; wi++) begin
            w    = 2'(wi);
            ones = fill_lanes(64'd1, w);
            issue_op(VADD, w, '1, ones, $sformatf("add wrap w%0d", wi));
            issue_op(VSUB, w, '0, ones, $sformatf("sub wrap w%0d", wi));
        end

        // max lane values, then a pattern that tells even from odd
        for (int wi = 0; wi < 3; wi++) begin
            w = 2'(wi);
            issue_op(VMULEU, w, '1, '1, $sformatf("muleu max w%0d", wi));
            issue_op(VMULOU, w, '1, '1, $sformatf("mulou max w%0d", wi));
            issue_op(VMULEU, w, 64'h123456789ABCDEF0, 64'h0F1E2D3C4B5A6978,
                     $sformatf("muleu pattern w%0d", wi));
            issue_op(VMULOU, w, 64'h123456789ABCDEF0, 64'h0F1E2D3C4B5A6978,
                     $sformatf("mulou pattern w%0d", wi));
        end
        issue_op(VMULEU, W_DWORD, '1, '1, "muleu dword zero");
        issue_op(VMULOU, W_DWORD, '1, '1, "mulou dword zero");

        // amounts 0, 1 and lane size minus one, with a bit above the amount field set
        for (int wi = 0; wi < 4; wi++) begin
            w    = 2'(wi);
            size = lane_size(w);
            for (int j = 0; j < 3; j++) begin
                amt   = (j == 0) ? 0 : ((j == 1) ? 1 : size - 1);
                amt_b = fill_lanes(64'(amt + size), w);
                issue_op(VSLL, w, 64'hF0E1D2C3B4A59687, amt_b,
                         $sformatf("sll w%0d amt %0d", wi, amt));
                issue_op(VSRL, w, 64'hF0E1D2C3B4A59687, amt_b,
                         $sformatf("srl w%0d amt %0d", wi, amt));
            end
        end
        for (int wi = 0; wi < 4; wi++) begin
            issue_op(VRTTH, 2'(wi), 64'h123456789ABCDEF0, '0, $sformatf("rtth w%0d", wi));
        end
        idle_cycle();

        // back to back issues with occasional idle gaps
        for (int n = 0; n < n_random; n++) begin
            issue_op(random_opcode(), 2'($urandom % 4), {$urandom, $urandom},
                     {$urandom, $urandom}, $sformatf("random %0d", n));
            if ($urandom % 8 == 0) begin
                idle_cycle();
            end
        end

        // let the last result be checked
        repeat (2) idle_cycle();
        $display("Test passed");
        $finish;
    end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# build the vector_alu testbench with verilator and run it
# exit status is the simulator's, a $fatal in the testbench gives non-zero

set -u
cd "$(dirname "$0")" || exit 1

top=vector_alu_tb
build_dir=obj_dir

# compile rtl and testbench from the file list
verilator --binary --timing -Wno-fatal \
    -f vector_alu.f \
    --top-module "$top" \
    -Mdir "$build_dir"
status=$?
if [ "$status" -ne 0 ]; then
    echo "build failed with status $status"
    exit "$status"
fi

# run the simulation
"./$build_dir/V$top"
status=$?
if [ "$status" -ne 0 ]; then
    echo "simulation failed with status $status"
    exit "$status"
fi

echo "simulation finished with status 0"
exit 0

// ==== src/result_select.sv ====
`timescale 1ns/1ns

`include "valu_params.svh"

module result_select
    import valu_lane_pkg::*;
(
    input  logic   clk,
    input  logic   arst_n,
    input  logic   op_valid,
    input  dword_t arith_result,
    input  logic   arith_hit,
    input  dword_t bitmanip_result,
    input  logic   bitmanip_hit,
    output dword_t alu_out,
    output logic   result_valid
);

    dword_t sel_result; // result of the claiming unit

    // claims never overlap so priority order does not matter
    always_comb begin
        if (arith_hit) begin
            sel_result = arith_result;
        end else if (bitmanip_hit) begin
            sel_result = bitmanip_result;
        end else begin
            sel_result = {`VALU_DATA_W{1'b0}}; // nop or undefined opcode
        end
    end

    // single output stage, one cycle from issue to result
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            alu_out      <= {`VALU_DATA_W{1'b0}};
            result_valid <= 1'b0;
        end else begin
            result_valid <= op_valid; // one pulse per issue
            if (op_valid) begin
                alu_out <= sel_result;
            end
            // idle cycles keep the last result on alu_out
        end
    end

endmodule

// ==== src/simd_arith.sv ====
`timescale 1ns/1ns

`include "valu_params.svh"

module simd_arith
    import valu_op_pkg::*, valu_lane_pkg::*;
(
    input  valu_op_e    alu_op,
    input  elem_width_e width,
    input  dword_t      reg_a_data,
    input  dword_t      reg_b_data,
    output dword_t      arith_result,
    output logic        arith_hit
);

    dword_t add_res;  // lane add, no carry across lanes
    dword_t sub_res;  // lane sub, no borrow across lanes
    dword_t mul_res;  // even or odd lane products
    logic   odd_sel;  // picks odd lanes for the multiply

    assign odd_sel = (alu_op == VMULOU);

    // add and sub, every lane is its own modulo 2^n adder
    always_comb begin
        add_res = '0;
        sub_res = '0;
        case (width)
            W_BYTE: begin
                for (int i = 0; i < lane_count(W_BYTE); i++) begin
                    add_res[i*8 +: 8] = reg_a_data[i*8 +: 8] + reg_b_data[i*8 +: 8];
                    sub_res[i*8 +: 8] = reg_a_data[i*8 +: 8] - reg_b_data[i*8 +: 8];
                end
            end
            W_HALF: begin
                for (int i = 0; i < lane_count(W_HALF); i++) begin
                    add_res[i*16 +: 16] = reg_a_data[i*16 +: 16] + reg_b_data[i*16 +: 16];
                    sub_res[i*16 +: 16] = reg_a_data[i*16 +: 16] - reg_b_data[i*16 +: 16];
                end
            end
            W_WORD: begin
                for (int i = 0; i < lane_count(W_WORD); i++) begin
                    add_res[i*32 +: 32] = reg_a_data[i*32 +: 32] + reg_b_data[i*32 +: 32];
                    sub_res[i*32 +: 32] = reg_a_data[i*32 +: 32] - reg_b_data[i*32 +: 32];
                end
            end
            default: begin // full 64-bit add/sub
                add_res = reg_a_data + reg_b_data;
                sub_res = reg_a_data - reg_b_data;
            end
        endcase
    end

    // even/odd multiply
    // slot k takes lane 2k (even) or 2k+1 (odd), products packed from the msb end
    always_comb begin
        int src;  // source lane of the current slot
        mul_res = '0;
        src = 0;
        case (width)
            W_BYTE: begin
                for (int k = 0; k < mul_slots(W_BYTE); k++) begin
                    src = 2*k + (odd_sel ? 1 : 0);
                    mul_res[k*16 +: 16] = reg_a_data[src*8 +: 8]
                                        * reg_b_data[src*8 +: 8]; // 8x8 -> 16
                end
            end
            W_HALF: begin
                for (int k = 0; k < mul_slots(W_HALF); k++) begin
                    src = 2*k + (odd_sel ? 1 : 0);
                    mul_res[k*32 +: 32] = reg_a_data[src*16 +: 16]
                                        * reg_b_data[src*16 +: 16]; // 16x16 -> 32
                end
            end
            W_WORD: begin
                src = odd_sel ? 1 : 0;
                mul_res = reg_a_data[src*32 +: 32] * reg_b_data[src*32 +: 32]; // one 64-bit product
            end
            default: mul_res = '0; // no 128-bit slot, doubleword multiply is zero
        endcase
    end

    // result pick and claim
    always_comb begin
        case (alu_op)
            VADD:          arith_result = add_res;
            VSUB:          arith_result = sub_res;
            VMULEU, VMULOU: arith_result = mul_res;
            default:       arith_result = '0;
        endcase
    end

    assign arith_hit = alu_op inside {VADD, VSUB, VMULEU, VMULOU};

endmodule

// ==== src/simd_bitmanip.sv ====
`timescale 1ns/1ns

`include "valu_params.svh"

module simd_bitmanip
    import valu_op_pkg::*, valu_lane_pkg::*;
(
    input  valu_op_e    alu_op,
    input  elem_width_e width,
    input  dword_t      reg_a_data,
    input  dword_t      reg_b_data,
    output dword_t      bitmanip_result,
    output logic        bitmanip_hit
);

    dword_t     shl_res;   // per lane logical left
    dword_t     shr_res;   // per lane logical right
    dword_t     rot_res;   // half swap per lane
    logic [5:0] amt_mask;  // 3, 4, 5 or 6 low bits of each b lane

    assign amt_mask = shamt_mask(width);

    // shifts and rotate
    // lanes are copied into little endian temps so [n:0] means the usual thing
    always_comb begin
        logic [7:0]  a8, b8;
        logic [15:0] a16, b16;
        logic [31:0] a32, b32;
        logic [63:0] a64;
        logic [5:0]  amt64;
        a8  = '0;
        b8  = '0;
        a16 = '0;
        b16 = '0;
        a32 = '0;
        b32 = '0;
        a64 = '0;
        amt64 = '0;
        shl_res = '0;
        shr_res = '0;
        rot_res = '0;
        case (width)
            W_BYTE: begin
                for (int i = 0; i < lane_count(W_BYTE); i++) begin
                    a8 = reg_a_data[i*8 +: 8];
                    b8 = reg_b_data[i*8 +: 8];
                    shl_res[i*8 +: 8] = a8 << (b8 & 8'(amt_mask)); // amount is b8[2:0]
                    shr_res[i*8 +: 8] = a8 >> (b8 & 8'(amt_mask));
                    rot_res[i*8 +: 8] = {a8[3:0], a8[7:4]}; // nibble swap
                end
            end
            W_HALF: begin
                for (int i = 0; i < lane_count(W_HALF); i++) begin
                    a16 = reg_a_data[i*16 +: 16];
                    b16 = reg_b_data[i*16 +: 16];
                    shl_res[i*16 +: 16] = a16 << (b16 & 16'(amt_mask));
                    shr_res[i*16 +: 16] = a16 >> (b16 & 16'(amt_mask));
                    rot_res[i*16 +: 16] = {a16[7:0], a16[15:8]}; // byte swap
                end
            end
            W_WORD: begin
                for (int i = 0; i < lane_count(W_WORD); i++) begin
                    a32 = reg_a_data[i*32 +: 32];
                    b32 = reg_b_data[i*32 +: 32];
                    shl_res[i*32 +: 32] = a32 << (b32 & 32'(amt_mask));
                    shr_res[i*32 +: 32] = a32 >> (b32 & 32'(amt_mask));
                    rot_res[i*32 +: 32] = {a32[15:0], a32[31:16]};
                end
            end
            default: begin
                // doubleword, amount from the 6 lsbs of b
                a64   = reg_a_data;
                amt64 = reg_b_data[58:63] & amt_mask;
                shl_res = a64 << amt64;
                shr_res = a64 >> amt64;
                rot_res = {a64[31:0], a64[63:32]};
            end
        endcase
    end

    // logic ops ignore width
    always_comb begin
        case (alu_op)
            VAND:    bitmanip_result = reg_a_data & reg_b_data;
            VOR:     bitmanip_result = reg_a_data | reg_b_data;
            VXOR:    bitmanip_result = reg_a_data ^ reg_b_data;
            VNOT:    bitmanip_result = ~reg_a_data; // b unused
            VSLL:    bitmanip_result = shl_res;
            VSRL:    bitmanip_result = shr_res;
            VRTTH:   bitmanip_result = rot_res;
            default: bitmanip_result = '0;
        endcase
    end

    // claim set, disjoint from the arith unit
    assign bitmanip_hit = alu_op inside {VAND, VOR, VXOR, VNOT, VSLL, VSRL, VRTTH};

endmodule

// ==== src/valu_lane_pkg.sv ====
`include "valu_params.svh"

package valu_lane_pkg;

    import valu_op_pkg::*;

    // big endian numbering, bit 0 is the msb and lane 0 holds it
    typedef logic [0:`VALU_DATA_W-1] dword_t;

    // lane size in bits for a width select
    function automatic int unsigned lane_bits(elem_width_e w);
        int unsigned bits;
        case (w)
            W_BYTE:  bits = 8;
            W_HALF:  bits = 16;
            W_WORD:  bits = 32;
            default: bits = 64; // doubleword
        endcase
        return bits;
    endfunction

    // number of lanes in one data word
    function automatic int unsigned lane_count(elem_width_e w);
        return `VALU_DATA_W / lane_bits(w);
    endfunction

    // double width product slots for even/odd multiply, half the lane count
    function automatic int unsigned mul_slots(elem_width_e w);
        int unsigned n;
        n = lane_count(w) / 2;
        return n;
    endfunction

    // shift amount mask, keeps the low log2(lane size) bits of a lane
    function automatic logic [5:0] shamt_mask(elem_width_e w);
        return 6'(lane_bits(w) - 1);
    endfunction

endpackage

// ==== src/valu_op_pkg.sv ====
`include "valu_params.svh"

package valu_op_pkg;

    // vector opcodes, codes that are not listed here are treated as unclaimed
    typedef enum logic [`VALU_OP_W-1:0] {
        VAND   = 6'd1,  // bitwise and
        VOR    = 6'd2,  // bitwise or
        VXOR   = 6'd3,  // bitwise xor
        VNOT   = 6'd4,  // invert operand a only
        VADD   = 6'd6,  // lane add, wraps inside the lane
        VSUB   = 6'd7,  // lane sub, wraps inside the lane
        VMULEU = 6'd8,  // unsigned multiply of lanes 0, 2, 4 ...
        VMULOU = 6'd9,  // unsigned multiply of lanes 1, 3, 5 ...
        VSLL   = 6'd10, // logical shift left per lane
        VSRL   = 6'd11, // logical shift right per lane
        VRTTH  = 6'd13, // swap upper and lower half of each lane
        VNOP   = 6'd23  // no unit claims it, result is zero
    } valu_op_e;

    // element width select
    // lane 0 always sits at the most significant end of the word
    typedef enum logic [`VALU_WIDTH_W-1:0] {
        W_BYTE  = 2'd0, // 8 lanes of 8 bits
        W_HALF  = 2'd1, // 4 lanes of 16 bits
        W_WORD  = 2'd2, // 2 lanes of 32 bits
        W_DWORD = 2'd3  // 1 lane of 64 bits
    } elem_width_e;

endpackage

// ==== src/valu_params.svh ====
`ifndef VALU_PARAMS_SVH
`define VALU_PARAMS_SVH

// operand and result word, one full register
`define VALU_DATA_W 64

// opcode field, same 6-bit encoding space as the scalar decode
`define VALU_OP_W 6

// element width select
// b h w d
`define VALU_WIDTH_W 2

`endif

// ==== src/vector_alu.sv ====
`timescale 1ns/1ns

`include "valu_params.svh"

module vector_alu
    import valu_op_pkg::*, valu_lane_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        op_valid,     // issue strobe, one op per cycle at most
    input  valu_op_e    alu_op,
    input  elem_width_e width,        // no effect on bitwise ops
    input  dword_t      reg_a_data,
    input  dword_t      reg_b_data,
    output dword_t      alu_out,      // registered result
    output logic        result_valid  // high for the one cycle alu_out is new
);

    dword_t arith_result;
    logic   arith_hit;
    dword_t bitmanip_result;
    logic   bitmanip_hit;

    // add, sub, even/odd multiply
    simd_arith arith_i (
        .alu_op       (alu_op),
        .width        (width),
        .reg_a_data   (reg_a_data),
        .reg_b_data   (reg_b_data),
        .arith_result (arith_result),
        .arith_hit    (arith_hit)
    );

    // logic ops, shifts, rotate by half
    simd_bitmanip bitmanip_i (
        .alu_op          (alu_op),
        .width           (width),
        .reg_a_data      (reg_a_data),
        .reg_b_data      (reg_b_data),
        .bitmanip_result (bitmanip_result),
        .bitmanip_hit    (bitmanip_hit)
    );

    // mux the claiming unit and register on issue
    result_select select_i (
        .clk             (clk),
        .arst_n          (arst_n),
        .op_valid        (op_valid),
        .arith_result    (arith_result),
        .arith_hit       (arith_hit),
        .bitmanip_result (bitmanip_result),
        .bitmanip_hit    (bitmanip_hit),
        .alu_out         (alu_out),
        .result_valid    (result_valid)
    );

endmodule

// ==== vector_alu.f ====
+incdir+src
src/valu_op_pkg.sv
src/valu_lane_pkg.sv
src/simd_arith.sv
src/simd_bitmanip.sv
src/result_select.sv
src/vector_alu.sv
dv/vector_alu_tb.sv
